// File: hdl/spi_axi_pkg.sv
package spi_axi_pkg;

  localparam int DATA_WIDTH    = 32;
  localparam int STRB_WIDTH    = DATA_WIDTH / 8;
  localparam int REG_IDX_WIDTH = 3;

  localparam logic [1:0] resp_okay = 2'b00;

  // Word index inside the register window
  typedef enum logic [REG_IDX_WIDTH-1:0] {
    STATUS = 3'd0,
    CLKDIV = 3'd1,
    SPICMD = 3'd2,
    SPIADR = 3'd3,
    SPILEN = 3'd4,
    SPIDUM = 3'd5,
    RXFIFO = 3'd6,
    TXFIFO = 3'd7
  } reg_idx_e;

  typedef struct packed {
    logic [7:0]  clk_div;
    logic [31:0] cmd;
    logic [31:0] addr;
    logic [5:0]  cmd_len;
    logic [5:0]  addr_len;
    logic [15:0] data_len;
    logic [15:0] dummy_rd;
    logic [15:0] dummy_wr;
    logic [3:0]  csreg;
  } spi_cfg_t;

  typedef struct packed {
    logic rd;
    logic wr;
    logic qrd;
    logic qwr;
    logic swrst;
    logic clk_div_valid;
  } spi_pulse_t;

  typedef struct packed {
    logic                  valid;
    reg_idx_e              idx;
    logic [DATA_WIDTH-1:0] data;
    logic [STRB_WIDTH-1:0] strb;
  } reg_wr_t;

  // STATUS write, commands in byte 0
  typedef struct packed {
    logic [15:0] rsvd_hi;
    logic [3:0]  rsvd_cs;
    logic [3:0]  csreg;
    logic [2:0]  rsvd_cmd;
    logic        swrst;
    logic        qwr;
    logic        qrd;
    logic        wr;
    logic        rd;
  } ctrl_view_t;

  typedef struct packed {
    logic [15:0] data_len;
    logic [1:0]  rsvd_addr;
    logic [5:0]  addr_len;
    logic [1:0]  rsvd_cmd;
    logic [5:0]  cmd_len;
  } len_view_t;

  typedef struct packed {
    logic [15:0] dummy_wr;
    logic [15:0] dummy_rd;
  } dum_view_t;

  typedef union packed {
    logic [DATA_WIDTH-1:0] raw;
    ctrl_view_t            ctrl_view;
    len_view_t             len_view;
    dum_view_t             dum_view;
  } reg_wdata_u;

endpackage

// File: hdl/spi_axi_wr_channel.sv
`timescale 1ns/1ps

module spi_axi_wr_channel #(
  parameter int AXI4_ADDRESS_WIDTH = 32,
  parameter int AXI4_ID_WIDTH      = 16
) (
  input  logic                                  s_axi_aclk,
  input  logic                                  s_axi_aresetn,

  input  logic                                  s_axi_awvalid,
  input  logic [AXI4_ID_WIDTH-1:0]              s_axi_awid,
  input  logic [AXI4_ADDRESS_WIDTH-1:0]         s_axi_awaddr,
  output logic                                  s_axi_awready,

  input  logic                                  s_axi_wvalid,
  input  logic [spi_axi_pkg::DATA_WIDTH-1:0]    s_axi_wdata,
  input  logic [spi_axi_pkg::STRB_WIDTH-1:0]    s_axi_wstrb,
  output logic                                  s_axi_wready,

  output logic                                  s_axi_bvalid,
  output logic [AXI4_ID_WIDTH-1:0]              s_axi_bid,
  output logic [1:0]                            s_axi_bresp,
  input  logic                                  s_axi_bready,

  output spi_axi_pkg::reg_wr_t                  reg_wr,
  output logic                                  spi_data_tx_valid,
  input  logic                                  spi_data_tx_ready
);

  localparam int IDX_LSB    = 2;
  localparam int IDX_MSB    = 6;
  localparam int WORD_WIDTH = IDX_MSB - IDX_LSB + 1;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_WAIT_DATA,
    WR_RESP
  } wr_state_e;

  wr_state_e               state_q;
  wr_state_e               state_d;
  logic [AXI4_ID_WIDTH-1:0] id_q;
  logic [WORD_WIDTH-1:0]   word_q;
  logic [WORD_WIDTH-1:0]   aw_word;
  logic [WORD_WIDTH-1:0]   cur_word;
  spi_axi_pkg::reg_idx_e   cur_idx;
  logic                    cur_hit;
  logic                    is_tx;
  logic                    data_ok;
  logic                    aw_hs;
  logic                    w_hs;

  assign aw_word  = s_axi_awaddr[IDX_MSB:IDX_LSB];
  assign cur_word = (state_q == WR_IDLE) ? aw_word : word_q; // Idle takes the incoming address
  assign cur_idx  = spi_axi_pkg::reg_idx_e'(cur_word[spi_axi_pkg::REG_IDX_WIDTH-1:0]);
  assign cur_hit  = (cur_word[WORD_WIDTH-1:spi_axi_pkg::REG_IDX_WIDTH] == '0);
  assign is_tx    = cur_hit && (cur_idx == spi_axi_pkg::TXFIFO);
  assign data_ok  = !is_tx || spi_data_tx_ready;

  assign aw_hs = s_axi_awvalid && s_axi_awready;
  assign w_hs  = s_axi_wvalid && s_axi_wready;

  always_comb
  begin
    s_axi_awready = 1'b0;
    s_axi_wready  = 1'b0;
    s_axi_bvalid  = 1'b0;
    state_d       = state_q;
    case (state_q)
      WR_IDLE:
      begin
        s_axi_awready = 1'b1;
        s_axi_wready  = s_axi_awvalid && data_ok;
        if (s_axi_awvalid)
          state_d = (s_axi_wvalid && data_ok) ? WR_RESP : WR_WAIT_DATA;
      end
      WR_WAIT_DATA:
      begin
        s_axi_wready = data_ok;
        if (s_axi_wvalid && data_ok)
          state_d = WR_RESP;
      end
      WR_RESP:
      begin
        s_axi_bvalid = 1'b1;
        if (s_axi_bready)
        begin
          // Next address only, its data comes a cycle later
          s_axi_awready = 1'b1;
          state_d       = s_axi_awvalid ? WR_WAIT_DATA : WR_IDLE;
        end
      end
      default:
        state_d = WR_IDLE;
    endcase
  end

  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn)
  begin
    if (!s_axi_aresetn)
      state_q <= WR_IDLE;
    else
      state_q <= state_d;
  end

  always_ff @(posedge s_axi_aclk)
  begin
    if (aw_hs)
    begin
      id_q   <= s_axi_awid;
      word_q <= aw_word;
    end
  end

  assign s_axi_bid   = id_q;
  assign s_axi_bresp = spi_axi_pkg::resp_okay;

  assign reg_wr = '{valid: w_hs && cur_hit, idx: cur_idx, data: s_axi_wdata, strb: s_axi_wstrb};
  assign spi_data_tx_valid = w_hs && is_tx;

  a_bvalid_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid && $stable(s_axi_bid));

  a_tx_push_ready: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    spi_data_tx_valid |-> spi_data_tx_ready);

endmodule

// File: hdl/spi_axi_rd_channel.sv
`timescale 1ns/1ps

module spi_axi_rd_channel #(
  parameter int AXI4_ADDRESS_WIDTH = 32,
  parameter int AXI4_ID_WIDTH      = 16
) (
  input  logic                                  s_axi_aclk,
  input  logic                                  s_axi_aresetn,

  input  logic                                  s_axi_arvalid,
  input  logic [AXI4_ID_WIDTH-1:0]              s_axi_arid,
  input  logic [AXI4_ADDRESS_WIDTH-1:0]         s_axi_araddr,
  output logic                                  s_axi_arready,

  output logic                                  s_axi_rvalid,
  output logic [AXI4_ID_WIDTH-1:0]              s_axi_rid,
  output logic [spi_axi_pkg::DATA_WIDTH-1:0]    s_axi_rdata,
  output logic [1:0]                            s_axi_rresp,
  output logic                                  s_axi_rlast,
  input  logic                                  s_axi_rready,

  output spi_axi_pkg::reg_idx_e                 rd_idx,
  input  logic [spi_axi_pkg::DATA_WIDTH-1:0]    rd_data,
  input  logic                                  spi_data_rx_valid,
  output logic                                  spi_data_rx_ready
);

  localparam int IDX_LSB    = 2;
  localparam int IDX_MSB    = 6;
  localparam int WORD_WIDTH = IDX_MSB - IDX_LSB + 1;

  typedef enum logic {
    RD_IDLE,
    RD_RESP
  } rd_state_e;

  rd_state_e                        state_q;
  logic                             first_q;
  logic [AXI4_ID_WIDTH-1:0]         id_q;
  logic [WORD_WIDTH-1:0]            word_q;
  logic [spi_axi_pkg::DATA_WIDTH-1:0] rdata_q;
  logic [spi_axi_pkg::DATA_WIDTH-1:0] rd_word;
  logic                             hit;
  logic                             rx_sel;
  logic                             accept_en;
  logic                             ar_hs;
  logic                             r_hs;

  assign rd_idx = spi_axi_pkg::reg_idx_e'(word_q[spi_axi_pkg::REG_IDX_WIDTH-1:0]);
  assign hit    = (word_q[WORD_WIDTH-1:spi_axi_pkg::REG_IDX_WIDTH] == '0);
  assign rx_sel = hit && (rd_idx == spi_axi_pkg::RXFIFO);

  // RX beats wait for FIFO data
  assign s_axi_rvalid = (state_q == RD_RESP) && (!rx_sel || spi_data_rx_valid);
  assign r_hs         = s_axi_rvalid && s_axi_rready;

  assign accept_en     = (state_q == RD_IDLE) || r_hs;
  assign s_axi_arready = accept_en;
  assign ar_hs         = s_axi_arvalid && accept_en;

  assign spi_data_rx_ready = r_hs && rx_sel; // Pop on the R handshake

  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn)
  begin
    if (!s_axi_aresetn)
    begin
      state_q <= RD_IDLE;
      first_q <= 1'b0;
    end
    else
    begin
      if (accept_en)
        state_q <= s_axi_arvalid ? RD_RESP : RD_IDLE;
      first_q <= ar_hs;
    end
  end

  always_ff @(posedge s_axi_aclk)
  begin
    if (ar_hs)
    begin
      id_q   <= s_axi_arid;
      word_q <= s_axi_araddr[IDX_MSB:IDX_LSB];
    end
    if (first_q)
      rdata_q <= rd_data; // Freeze the word for a stalled beat
  end

  assign rd_word = first_q ? rd_data : rdata_q;

  always_comb
  begin
    if (!hit)
      s_axi_rdata = '0;
    else if (rx_sel)
      s_axi_rdata = rd_data;
    else
      s_axi_rdata = rd_word;
  end

  assign s_axi_rid   = id_q;
  assign s_axi_rresp = spi_axi_pkg::resp_okay;
  assign s_axi_rlast = (state_q == RD_RESP);

  // Register reads hold their word while stalled
  a_rdata_stable: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    s_axi_rvalid && !s_axi_rready && !rx_sel |=> $stable(s_axi_rdata));

endmodule

// File: hdl/spi_ctrl_regs.sv
`timescale 1ns/1ps

module spi_ctrl_regs (
  input  logic                               s_axi_aclk,
  input  logic                               s_axi_aresetn,

  input  spi_axi_pkg::reg_wr_t               reg_wr,
  input  spi_axi_pkg::reg_idx_e              rd_idx,
  output logic [spi_axi_pkg::DATA_WIDTH-1:0] rd_data,

  input  logic [spi_axi_pkg::DATA_WIDTH-1:0] spi_status,
  input  logic [spi_axi_pkg::DATA_WIDTH-1:0] spi_data_rx,
  output spi_axi_pkg::spi_cfg_t              spi_cfg,
  output spi_axi_pkg::spi_pulse_t            spi_pulse
);

  spi_axi_pkg::reg_wdata_u wd;

  assign wd.raw = reg_wr.data;

  function automatic logic [spi_axi_pkg::DATA_WIDTH-1:0] strobe_merge(
    input logic [spi_axi_pkg::DATA_WIDTH-1:0] old_word,
    input logic [spi_axi_pkg::DATA_WIDTH-1:0] new_word,
    input logic [spi_axi_pkg::STRB_WIDTH-1:0] strb
  );
    logic [spi_axi_pkg::DATA_WIDTH-1:0] merged;
    merged = old_word;
    for (int b = 0; b < spi_axi_pkg::STRB_WIDTH; b++)
    begin
      if (strb[b])
        merged[8*b +: 8] = new_word[8*b +: 8];
    end
    return merged;
  endfunction

  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn)
  begin
    if (!s_axi_aresetn)
    begin
      spi_cfg   <= '0;
      spi_pulse <= '0;
    end
    else
    begin
      spi_pulse <= '0; // Pulses last one cycle
      if (reg_wr.valid)
      begin
        case (reg_wr.idx)
          spi_axi_pkg::STATUS:
          begin
            if (reg_wr.strb[0])
            begin
              spi_pulse.rd    <= wd.ctrl_view.rd;
              spi_pulse.wr    <= wd.ctrl_view.wr;
              spi_pulse.qrd   <= wd.ctrl_view.qrd;
              spi_pulse.qwr   <= wd.ctrl_view.qwr;
              spi_pulse.swrst <= wd.ctrl_view.swrst;
            end
            if (reg_wr.strb[1])
              spi_cfg.csreg <= wd.ctrl_view.csreg;
          end
          spi_axi_pkg::CLKDIV:
          begin
            if (reg_wr.strb[0])
            begin
              spi_cfg.clk_div         <= wd.raw[7:0];
              spi_pulse.clk_div_valid <= 1'b1;
            end
          end
          spi_axi_pkg::SPICMD:
            spi_cfg.cmd <= strobe_merge(spi_cfg.cmd, wd.raw, reg_wr.strb);
          spi_axi_pkg::SPIADR:
            spi_cfg.addr <= strobe_merge(spi_cfg.addr, wd.raw, reg_wr.strb);
          spi_axi_pkg::SPILEN:
          begin
            if (reg_wr.strb[0])
              spi_cfg.cmd_len <= wd.len_view.cmd_len;
            if (reg_wr.strb[1])
              spi_cfg.addr_len <= wd.len_view.addr_len;
            if (reg_wr.strb[2])
              spi_cfg.data_len[7:0] <= wd.len_view.data_len[7:0];
            if (reg_wr.strb[3])
              spi_cfg.data_len[15:8] <= wd.len_view.data_len[15:8];
          end
          spi_axi_pkg::SPIDUM:
          begin
            if (reg_wr.strb[0])
              spi_cfg.dummy_rd[7:0] <= wd.dum_view.dummy_rd[7:0];
            if (reg_wr.strb[1])
              spi_cfg.dummy_rd[15:8] <= wd.dum_view.dummy_rd[15:8];
            if (reg_wr.strb[2])
              spi_cfg.dummy_wr[7:0] <= wd.dum_view.dummy_wr[7:0];
            if (reg_wr.strb[3])
              spi_cfg.dummy_wr[15:8] <= wd.dum_view.dummy_wr[15:8];
          end
          default:
          begin
            // FIFO indices leave the configuration alone
          end
        endcase
      end
    end
  end

  always_comb
  begin
    case (rd_idx)
      spi_axi_pkg::STATUS: rd_data = spi_status;
      spi_axi_pkg::CLKDIV: rd_data = {24'h0, spi_cfg.clk_div};
      spi_axi_pkg::SPICMD: rd_data = spi_cfg.cmd;
      spi_axi_pkg::SPIADR: rd_data = spi_cfg.addr;
      spi_axi_pkg::SPILEN:
        rd_data = {spi_cfg.data_len, 2'b00, spi_cfg.addr_len, 2'b00, spi_cfg.cmd_len};
      spi_axi_pkg::SPIDUM: rd_data = {spi_cfg.dummy_wr, spi_cfg.dummy_rd};
      default:             rd_data = spi_data_rx; // RX and TX windows
    endcase
  end

  // Write beats are at least two cycles apart
  a_pulse_single: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    spi_pulse != '0 |=> spi_pulse == '0);

endmodule

// File: hdl/spi_master_axi_if.sv
`timescale 1ns/1ps

module spi_master_axi_if #(
  parameter int AXI4_ADDRESS_WIDTH = 32,
  parameter int AXI4_ID_WIDTH      = 16
) (
  input  logic                               s_axi_aclk,
  input  logic                               s_axi_aresetn,

  input  logic                               s_axi_awvalid,
  input  logic [AXI4_ID_WIDTH-1:0]           s_axi_awid,
  input  logic [AXI4_ADDRESS_WIDTH-1:0]      s_axi_awaddr,
  output logic                               s_axi_awready,

  input  logic                               s_axi_wvalid,
  input  logic [spi_axi_pkg::DATA_WIDTH-1:0] s_axi_wdata,
  input  logic [spi_axi_pkg::STRB_WIDTH-1:0] s_axi_wstrb,
  output logic                               s_axi_wready,

  output logic                               s_axi_bvalid,
  output logic [AXI4_ID_WIDTH-1:0]           s_axi_bid,
  output logic [1:0]                         s_axi_bresp,
  input  logic                               s_axi_bready,

  input  logic                               s_axi_arvalid,
  input  logic [AXI4_ID_WIDTH-1:0]           s_axi_arid,
  input  logic [AXI4_ADDRESS_WIDTH-1:0]      s_axi_araddr,
  output logic                               s_axi_arready,

  output logic                               s_axi_rvalid,
  output logic [AXI4_ID_WIDTH-1:0]           s_axi_rid,
  output logic [spi_axi_pkg::DATA_WIDTH-1:0] s_axi_rdata,
  output logic [1:0]                         s_axi_rresp,
  output logic                               s_axi_rlast,
  input  logic                               s_axi_rready,

  output spi_axi_pkg::spi_cfg_t              spi_cfg,
  output spi_axi_pkg::spi_pulse_t            spi_pulse,
  input  logic [spi_axi_pkg::DATA_WIDTH-1:0] spi_status,
  output logic [spi_axi_pkg::DATA_WIDTH-1:0] spi_data_tx,
  output logic                               spi_data_tx_valid,
  input  logic                               spi_data_tx_ready,
  input  logic [spi_axi_pkg::DATA_WIDTH-1:0] spi_data_rx,
  input  logic                               spi_data_rx_valid,
  output logic                               spi_data_rx_ready
);

  spi_axi_pkg::reg_wr_t               reg_wr;
  spi_axi_pkg::reg_idx_e              rd_idx;
  logic [spi_axi_pkg::DATA_WIDTH-1:0] rd_data;

  assign spi_data_tx = s_axi_wdata; // Valid only on a TX data beat

  spi_axi_wr_channel #(
    .AXI4_ADDRESS_WIDTH (AXI4_ADDRESS_WIDTH),
    .AXI4_ID_WIDTH      (AXI4_ID_WIDTH)
  ) u_wr_channel (
    .s_axi_aclk         (s_axi_aclk),
    .s_axi_aresetn      (s_axi_aresetn),
    .s_axi_awvalid      (s_axi_awvalid),
    .s_axi_awid         (s_axi_awid),
    .s_axi_awaddr       (s_axi_awaddr),
    .s_axi_awready      (s_axi_awready),
    .s_axi_wvalid       (s_axi_wvalid),
    .s_axi_wdata        (s_axi_wdata),
    .s_axi_wstrb        (s_axi_wstrb),
    .s_axi_wready       (s_axi_wready),
    .s_axi_bvalid       (s_axi_bvalid),
    .s_axi_bid          (s_axi_bid),
    .s_axi_bresp        (s_axi_bresp),
    .s_axi_bready       (s_axi_bready),
    .reg_wr             (reg_wr),
    .spi_data_tx_valid  (spi_data_tx_valid),
    .spi_data_tx_ready  (spi_data_tx_ready)
  );

  spi_axi_rd_channel #(
    .AXI4_ADDRESS_WIDTH (AXI4_ADDRESS_WIDTH),
    .AXI4_ID_WIDTH      (AXI4_ID_WIDTH)
  ) u_rd_channel (
    .s_axi_aclk         (s_axi_aclk),
    .s_axi_aresetn      (s_axi_aresetn),
    .s_axi_arvalid      (s_axi_arvalid),
    .s_axi_arid         (s_axi_arid),
    .s_axi_araddr       (s_axi_araddr),
    .s_axi_arready      (s_axi_arready),
    .s_axi_rvalid       (s_axi_rvalid),
    .s_axi_rid          (s_axi_rid),
    .s_axi_rdata        (s_axi_rdata),
    .s_axi_rresp        (s_axi_rresp),
    .s_axi_rlast        (s_axi_rlast),
    .s_axi_rready       (s_axi_rready),
    .rd_idx             (rd_idx),
    .rd_data            (rd_data),
    .spi_data_rx_valid  (spi_data_rx_valid),
    .spi_data_rx_ready  (spi_data_rx_ready)
  );

  spi_ctrl_regs u_ctrl_regs (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .reg_wr        (reg_wr),
    .rd_idx        (rd_idx),
    .rd_data       (rd_data),
    .spi_status    (spi_status),
    .spi_data_rx   (spi_data_rx),
    .spi_cfg       (spi_cfg),
    .spi_pulse     (spi_pulse)
  );

endmodule

// File: tests/tb_spi_master_axi_if.sv
`timescale 1ns/1ps

module tb_spi_master_axi_if;

  localparam int TIMEOUT_CYCLES = 100;

  logic                    s_axi_aclk;
  logic                    s_axi_aresetn;
  logic                    s_axi_awvalid;
  logic [15:0]             s_axi_awid;
  logic [31:0]             s_axi_awaddr;
  logic                    s_axi_awready;
  logic                    s_axi_wvalid;
  logic [31:0]             s_axi_wdata;
  logic [3:0]              s_axi_wstrb;
  logic                    s_axi_wready;
  logic                    s_axi_bvalid;
  logic [15:0]             s_axi_bid;
  logic [1:0]              s_axi_bresp;
  logic                    s_axi_bready;
  logic                    s_axi_arvalid;
  logic [15:0]             s_axi_arid;
  logic [31:0]             s_axi_araddr;
  logic                    s_axi_arready;
  logic                    s_axi_rvalid;
  logic [15:0]             s_axi_rid;
  logic [31:0]             s_axi_rdata;
  logic [1:0]              s_axi_rresp;
  logic                    s_axi_rlast;
  logic                    s_axi_rready;
  spi_axi_pkg::spi_cfg_t   spi_cfg;
  spi_axi_pkg::spi_pulse_t spi_pulse;
  logic [31:0]             spi_status;
  logic [31:0]             spi_data_tx;
  logic                    spi_data_tx_valid;
  logic                    spi_data_tx_ready;
  logic [31:0]             spi_data_rx;
  logic                    spi_data_rx_valid;
  logic                    spi_data_rx_ready;

  integer                  seed = 32'ha4ab8de2;
  int                      error_count = 0;
  int                      pulse_cycles = 0;
  int                      tx_pushes = 0;
  int                      tx_writes = 0;
  int                      rx_pops = 0;
  int                      rx_reads = 0;
  spi_axi_pkg::spi_pulse_t pulse_last;
  spi_axi_pkg::spi_cfg_t   cfg_model;
  logic [31:0]             status_word;
  logic [31:0]             tx_word;

  spi_master_axi_if #(
    .AXI4_ADDRESS_WIDTH (32),
    .AXI4_ID_WIDTH      (16)
  ) UUT (.*);

  initial
  begin
    s_axi_aclk = 1'b0;
    forever #5 s_axi_aclk = ~s_axi_aclk;
  end

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  task automatic report_mismatch(input string name,
                                 input logic [$bits(spi_axi_pkg::spi_cfg_t)-1:0] got,
                                 input logic [$bits(spi_axi_pkg::spi_cfg_t)-1:0] exp);
    error_count++;
    $display("Error at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
  endtask

  task automatic report_fail(input string msg);
    error_count++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  task automatic abort_on_timeout(input string what);
    error_count++;
    $display("Timeout at %0t: the %s handshake never completed", $time, what);
    $display("Finished with %0d errors", error_count);
    $display("Test failed");
    $finish;
  endtask

  // One clock edge, then the side monitors and fresh random stalls
  task automatic next_cycle();
    logic [31:0] r;
    @(posedge s_axi_aclk);
    if (spi_pulse != '0)
    begin
      pulse_cycles++;
      pulse_last = spi_pulse;
    end
    if (spi_data_tx_valid)
    begin
      tx_pushes++;
      if (!spi_data_tx_ready)
        report_fail("spi_data_tx_valid high while spi_data_tx_ready is low");
      if (spi_data_tx != tx_word)
        report_mismatch("spi_data_tx", spi_data_tx, tx_word);
    end
    if (spi_data_rx_ready)
      rx_pops++;
    r = rand32();
    s_axi_bready      <= r[0] | r[1];  // Mostly ready
    s_axi_rready      <= r[2] | r[3];
    spi_data_tx_ready <= r[4];
    spi_data_rx_valid <= r[5];
    spi_data_rx       <= rand32();
  endtask

  function automatic spi_axi_pkg::spi_cfg_t model_write(input spi_axi_pkg::spi_cfg_t cfg,
    input logic [2:0] idx, input logic [31:0] data, input logic [3:0] strb);
    spi_axi_pkg::spi_cfg_t upd;
    upd = cfg;
    case (idx)
      spi_axi_pkg::STATUS: if (strb[1]) upd.csreg = data[11:8];
      spi_axi_pkg::CLKDIV: if (strb[0]) upd.clk_div = data[7:0];
      spi_axi_pkg::SPICMD:
        for (int b = 0; b < 4; b++)
          if (strb[b]) upd.cmd[8*b +: 8] = data[8*b +: 8];
      spi_axi_pkg::SPIADR:
        for (int b = 0; b < 4; b++)
          if (strb[b]) upd.addr[8*b +: 8] = data[8*b +: 8];
      spi_axi_pkg::SPILEN:
      begin
        if (strb[0]) upd.cmd_len = data[5:0];
        if (strb[1]) upd.addr_len = data[13:8];
        if (strb[2]) upd.data_len[7:0] = data[23:16];
        if (strb[3]) upd.data_len[15:8] = data[31:24];
      end
      spi_axi_pkg::SPIDUM:
      begin
        if (strb[0]) upd.dummy_rd[7:0] = data[7:0];
        if (strb[1]) upd.dummy_rd[15:8] = data[15:8];
        if (strb[2]) upd.dummy_wr[7:0] = data[23:16];
        if (strb[3]) upd.dummy_wr[15:8] = data[31:24];
      end
      default: ;
    endcase
    return upd;
  endfunction

  function automatic logic [31:0] model_read(input logic [2:0] idx);
    case (idx)
      spi_axi_pkg::STATUS: return status_word;
      spi_axi_pkg::CLKDIV: return {24'h0, cfg_model.clk_div};
      spi_axi_pkg::SPICMD: return cfg_model.cmd;
      spi_axi_pkg::SPIADR: return cfg_model.addr;
      spi_axi_pkg::SPILEN:
        return {cfg_model.data_len, 2'b00, cfg_model.addr_len, 2'b00, cfg_model.cmd_len};
      spi_axi_pkg::SPIDUM: return {cfg_model.dummy_wr, cfg_model.dummy_rd};
      default:             return spi_data_rx;
    endcase
  endfunction

  task automatic axi_write(input logic [2:0] idx, input logic [31:0] data,
                           input logic [3:0] strb, input int gap);
    logic [15:0]             id;
    spi_axi_pkg::spi_pulse_t exp_pulse;
    int                      t;
    bit                      aw_done;
    bit                      w_done;
    bit                      b_hold;
    id = rand32();
    exp_pulse = '0;
    if (idx == spi_axi_pkg::STATUS && strb[0])
      exp_pulse = '{rd: data[0], wr: data[1], qrd: data[2], qwr: data[3], swrst: data[4],
                    clk_div_valid: 1'b0};
    if (idx == spi_axi_pkg::CLKDIV && strb[0])
      exp_pulse.clk_div_valid = 1'b1;
    pulse_cycles = 0;
    tx_word = data;
    s_axi_awvalid <= 1'b1;
    s_axi_awaddr  <= {27'h0, idx, 2'b00};
    s_axi_awid    <= id;
    s_axi_wdata   <= data;
    s_axi_wstrb   <= strb;
    s_axi_wvalid  <= (gap == 0);
    aw_done = 0;
    w_done = 0;
    t = 0;
    while (!aw_done)
    begin
      next_cycle();
      t++;
      if (t > TIMEOUT_CYCLES) abort_on_timeout("AW");
      if (s_axi_wvalid && s_axi_wready)
        w_done = 1;
      if (s_axi_awvalid && s_axi_awready)
        aw_done = 1;
    end
    s_axi_awvalid <= 1'b0;
    if (w_done)
      s_axi_wvalid <= 1'b0;
    repeat (gap) next_cycle();  // Address leads the data
    s_axi_wvalid <= !w_done;
    t = 0;
    while (!w_done)
    begin
      next_cycle();
      t++;
      if (t > TIMEOUT_CYCLES) abort_on_timeout("W");
      if (s_axi_wvalid && s_axi_wready)
      begin
        w_done = 1;
        s_axi_wvalid <= 1'b0;
      end
    end
    cfg_model = model_write(cfg_model, idx, data, strb);
    if (idx == spi_axi_pkg::TXFIFO)
      tx_writes++;
    b_hold = 0;
    t = 0;
    while (!(s_axi_bvalid && s_axi_bready))
    begin
      next_cycle();
      t++;
      if (t > TIMEOUT_CYCLES) abort_on_timeout("B");
      if (b_hold && !s_axi_bvalid)
        report_fail("bvalid dropped before bready");
      b_hold = s_axi_bvalid && !s_axi_bready;
      if (s_axi_wready)
        report_fail("wready high with no write address pending");
      if (s_axi_bvalid && s_axi_bid != id)
        report_mismatch("s_axi_bid", s_axi_bid, id);
      if (s_axi_bvalid && s_axi_bresp != spi_axi_pkg::resp_okay)
        report_mismatch("s_axi_bresp", s_axi_bresp, spi_axi_pkg::resp_okay);
    end
    if (spi_cfg != cfg_model)
      report_mismatch("spi_cfg", spi_cfg, cfg_model);
    if (pulse_cycles != ((exp_pulse != '0) ? 1 : 0))
      report_mismatch("spi_pulse cycle count", pulse_cycles, (exp_pulse != '0) ? 1 : 0);
    if (exp_pulse != '0 && pulse_last != exp_pulse)
      report_mismatch("spi_pulse", pulse_last, exp_pulse);
  endtask

  task automatic axi_read(input logic [2:0] idx);
    logic [15:0] id;
    logic [31:0] exp_data;
    int          t;
    bit          done;
    bit          r_hold;
    id = rand32();
    s_axi_arvalid <= 1'b1;
    s_axi_araddr  <= {27'h0, idx, 2'b00};
    s_axi_arid    <= id;
    t = 0;
    done = 0;
    while (!done)
    begin
      next_cycle();
      t++;
      if (t > TIMEOUT_CYCLES) abort_on_timeout("AR");
      done = s_axi_arvalid && s_axi_arready;
    end
    s_axi_arvalid <= 1'b0;
    t = 0;
    done = 0;
    r_hold = 0;
    while (!done)
    begin
      next_cycle();
      t++;
      if (t > TIMEOUT_CYCLES) abort_on_timeout("R");
      if (r_hold && !s_axi_rvalid)
        report_fail("rvalid dropped before rready");
      r_hold = s_axi_rvalid && !s_axi_rready && idx != spi_axi_pkg::RXFIFO;
      if (s_axi_rvalid)
      begin
        exp_data = model_read(idx);
        if (s_axi_rdata != exp_data)
          report_mismatch("s_axi_rdata", s_axi_rdata, exp_data);
        if (s_axi_rid != id)
          report_mismatch("s_axi_rid", s_axi_rid, id);
        if (s_axi_rresp != spi_axi_pkg::resp_okay)
          report_mismatch("s_axi_rresp", s_axi_rresp, spi_axi_pkg::resp_okay);
        if (!s_axi_rlast)
          report_mismatch("s_axi_rlast", s_axi_rlast, 1'b1);
        done = s_axi_rready;
        if (done && idx == spi_axi_pkg::RXFIFO)
        begin
          rx_reads++;
          if (!spi_data_rx_ready)
            report_fail("spi_data_rx_ready low at an RX FIFO read");
        end
      end
    end
  endtask

  initial
  begin
    logic [31:0] r;
    logic [2:0]  idx;
    cfg_model = '0;
    status_word = '0;
    tx_word = '0;
    s_axi_aresetn     <= 1'b0;
    s_axi_awvalid     <= 1'b0;
    s_axi_awid        <= '0;
    s_axi_awaddr      <= '0;
    s_axi_wvalid      <= 1'b0;
    s_axi_wdata       <= '0;
    s_axi_wstrb       <= '0;
    s_axi_bready      <= 1'b0;
    s_axi_arvalid     <= 1'b0;
    s_axi_arid        <= '0;
    s_axi_araddr      <= '0;
    s_axi_rready      <= 1'b0;
    spi_status        <= '0;
    spi_data_tx_ready <= 1'b0;
    spi_data_rx       <= '0;
    spi_data_rx_valid <= 1'b0;
    repeat (3) @(posedge s_axi_aclk);
    s_axi_aresetn <= 1'b1;
    next_cycle();
    if (s_axi_bvalid || s_axi_rvalid || spi_data_tx_valid || spi_data_rx_ready)
      report_fail("a valid or ready output is high after reset");
    if (spi_pulse != '0)
      report_mismatch("spi_pulse", spi_pulse, 0);
    if (spi_cfg != '0)
      report_mismatch("spi_cfg", spi_cfg, 0);

    for (int i = 0; i < 40; i++)
    begin
      r = rand32();
      idx = 3'd1 + r % 5;  // CLKDIV up to SPIDUM
      axi_write(idx, rand32(), r[7:4], 0);
      axi_read(idx);
    end

    for (int i = 0; i < 10; i++)
    begin
      r = rand32();
      status_word = rand32();
      spi_status <= status_word;
      axi_write(spi_axi_pkg::STATUS, rand32(), r[3:0], 0);
      axi_write(spi_axi_pkg::CLKDIV, rand32(), r[7:4], 0);
      axi_read(spi_axi_pkg::STATUS);
    end

    for (int i = 0; i < 20; i++)
      axi_write(spi_axi_pkg::TXFIFO, rand32(), 4'hf, i % 3);
    for (int i = 0; i < 20; i++)
      axi_read(spi_axi_pkg::RXFIFO);

    // Late data beats under random B and R stalls
    for (int i = 0; i < 20; i++)
    begin
      r = rand32();
      idx = 3'd1 + r % 5;
      axi_write(idx, rand32(), r[7:4], 2 + r[9:8]);
      axi_read(idx);
    end

    if (tx_pushes != tx_writes)
      report_mismatch("TX push count", tx_pushes, tx_writes);
    if (rx_pops != rx_reads)
      report_mismatch("RX pop count", rx_pops, rx_reads);

    $display("Finished with %0d errors", error_count);
    if (error_count == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// File: vlog.f
hdl/spi_axi_pkg.sv
hdl/spi_axi_wr_channel.sv
hdl/spi_axi_rd_channel.sv
hdl/spi_ctrl_regs.sv
hdl/spi_master_axi_if.sv
tests/tb_spi_master_axi_if.sv

// File: Bender.yml
package:
  name: spi_master_axi_if

sources:
  # Package first, then the channels, the register block and the top level
  - hdl/spi_axi_pkg.sv
  - hdl/spi_axi_wr_channel.sv
  - hdl/spi_axi_rd_channel.sv
  - hdl/spi_ctrl_regs.sv
  - hdl/spi_master_axi_if.sv

  - target: test
    files:
      - tests/tb_spi_master_axi_if.sv
